/* src.f */
design/geom_pkg.sv
design/mvp_regs_apb.sv
design/stream_fifo.sv
design/mat_vec_mul.sv
design/vertex_shader.sv
design/geom_top.sv
sim/tb_clkgen.sv
sim/geom_props.sv
sim/geom_tb.sv

/* Bender.yml */
package:
  name: geom_front

sources:
  - design/geom_pkg.sv
  - design/mvp_regs_apb.sv
  - design/stream_fifo.sv
  - design/mat_vec_mul.sv
  - design/vertex_shader.sv
  - design/geom_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/geom_props.sv
      - sim/geom_tb.sv

/* sim/geom_tb.sv */
`timescale 1ns/1ps

module geom_tb;
    import geom_pkg::*;

    localparam int N_CASES = 4;
    localparam int MAX_VTX = 64;

    logic clk;
    logic rstn;

    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [APB_AW-1:0]   paddr;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic                vtx_valid;
    logic                vtx_ready;
    coord_t              vtx_x;
    coord_t              vtx_y;
    coord_t              vtx_z;
    logic                vtx_last;
    logic                out_valid;
    logic                out_ready;
    coord_t              out_x;
    coord_t              out_y;
    coord_t              out_z;
    coord_t              out_w;
    logic                out_last;

    // Case table: matrix, vertex count, sink pattern, commit after filling
    coord_t      mat_tab [3][16];
    int          case_mat [N_CASES];
    int          case_nvtx [N_CASES];
    int          case_mode [N_CASES];
    bit          case_late [N_CASES];
    int          case_first [N_CASES];
    in_vertex_t  vtx_tab [MAX_VTX];
    out_vertex_t exp_tab [MAX_VTX];

    int          seed;
    int          sent;
    int          err_count;
    bit          table_ready;

    tb_clkgen u_clkgen (
        .o_clk  (clk),
        .o_rstn (rstn)
    );

    geom_top uut (
        .clk         (clk),
        .rstn        (rstn),
        .i_psel      (psel),
        .i_penable   (penable),
        .i_pwrite    (pwrite),
        .i_paddr     (paddr),
        .i_pwdata    (pwdata),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .i_vtx_valid (vtx_valid),
        .o_vtx_ready (vtx_ready),
        .i_vtx_x     (vtx_x),
        .i_vtx_y     (vtx_y),
        .i_vtx_z     (vtx_z),
        .i_vtx_last  (vtx_last),
        .o_out_valid (out_valid),
        .i_out_ready (out_ready),
        .o_out_x     (out_x),
        .o_out_y     (out_y),
        .o_out_z     (out_z),
        .o_out_w     (out_w),
        .o_out_last  (out_last)
    );

    task automatic report_failure(input string msg);
        err_count++;
        $display("** Error at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vertex(input out_vertex_t got, input out_vertex_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h %h %h %h last %b, expected %h %h %h %h last %b",
                what, got.x, got.y, got.z, got.w, got.last,
                exp.x, exp.y, exp.z, exp.w, exp.last));
        end
    endtask

    task automatic check_word(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            report_failure("a concurrent assertion in geom_props failed");
        end
    end

    // Each product shifted right by FRACBITS, sums wrap to DATAWIDTH
    function automatic out_vertex_t transform_ref(input int m, input in_vertex_t v);
        coord_t                        vec [4];
        coord_t                        acc [4];
        logic signed [2*DATAWIDTH-1:0] p;
        out_vertex_t                   r;
        vec[0] = v.x;
        vec[1] = v.y;
        vec[2] = v.z;
        vec[3] = FIXED_ONE;
        for (int row = 0; row < 4; row++) begin
            acc[row] = '0;
            for (int col = 0; col < 4; col++) begin
                p = mat_tab[m][4*row+col] * vec[col];
                acc[row] = acc[row] + p[DATAWIDTH+FRACBITS-1:FRACBITS];
            end
        end
        r = '{x: acc[0], y: acc[1], z: acc[2], w: acc[3], last: v.last};
        return r;
    endfunction

    task automatic build_table();
        int first;
        int idx;
        mat_tab[0] = '{FIXED_ONE, 0, 0, 0, 0, FIXED_ONE, 0, 0,
                       0, 0, FIXED_ONE, 0, 0, 0, 0, FIXED_ONE};
        // Negative and fractional entries, some not exact in binary
        mat_tab[1] = '{12288, -2048, 1024, 16384, 2458, 7168, -9216, -4096,
                       -512, 3277, -8192, 26624, 0, 0, -8192, 0};
        // Large entries so that the row sums wrap
        mat_tab[2] = '{2457600, -3690496, 8192, 0, -8, 5734400, -6144, 819200,
                       4194222, -4194304, 164, -24576, 4096, 4096, 4096, 8192};
        case_mat = '{0, 1, 2, 1};
        case_nvtx = '{4, 6, 24, 20};
        case_mode = '{0, 0, 1, 2};
        case_late = '{0, 0, 0, 1};
        first = 0;
        for (int c = 0; c < N_CASES; c++) begin
            case_first[c] = first;
            for (int k = 0; k < case_nvtx[c]; k++) begin
                idx = first + k;
                vtx_tab[idx].x = coord_t'($random(seed) % 131072);
                vtx_tab[idx].y = coord_t'($random(seed) % 131072);
                vtx_tab[idx].z = coord_t'($random(seed) % 131072);
                vtx_tab[idx].last = (k == case_nvtx[c] - 1);
                exp_tab[idx] = transform_ref(case_mat[c], vtx_tab[idx]);
            end
            first += case_nvtx[c];
        end
        table_ready = 1'b1;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        check_bit(pready, 1'b1, "pready in the write access phase");
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        check_bit(pready, 1'b1, "pready in the read access phase");
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_status(input logic [APB_DW-1:0] mask, input string what,
                               output logic [APB_DW-1:0] data);
        logic err;
        int   tries;
        tries = 0;
        data = '0;
        while ((data & mask) != mask && tries < 100) begin
            apb_read(ADDR_STATUS, data, err);
            tries++;
        end
        if ((data & mask) != mask) begin
            report_failure({"timed out waiting for ", what});
        end
    endtask

    task automatic load_matrix(input int c);
        int                m;
        logic [APB_DW-1:0] d;
        logic              e;
        m = case_mat[c];
        for (int k = 0; k < 16; k++) begin
            apb_write(ADDR_MAT_BASE + APB_AW'(4 * k), APB_DW'(mat_tab[m][k]), e);
            check_bit(e, 1'b0, "slave error on matrix write");
        end
        for (int k = 0; k < 16; k++) begin
            apb_read(ADDR_MAT_BASE + APB_AW'(4 * k), d, e);
            check_word(d, APB_DW'(mat_tab[m][k]), $sformatf("matrix word %0d readback", k));
            check_bit(e, 1'b0, "slave error on matrix read");
        end
        apb_write(ADDR_CTRL, 32'h1, e);
        wait_status(32'h1, "ready after commit", d);
        check_word(d, 32'h1, "status after commit");
    endtask

    task automatic send_vertices(input int c);
        in_vertex_t v;
        int         k;
        k = 0;
        while (k < case_nvtx[c]) begin
            @(negedge clk);
            v = vtx_tab[case_first[c] + k];
            vtx_valid = 1'b1;
            vtx_x = v.x;
            vtx_y = v.y;
            vtx_z = v.z;
            vtx_last = v.last;
            #1;
            if (vtx_ready) begin
                k++;
                sent = k;
            end
        end
        @(negedge clk);
        vtx_valid = 1'b0;
        vtx_last = 1'b0;
    endtask

    task automatic collect_outputs(input int c);
        out_vertex_t got;
        logic [31:0] rnd;
        int          k;
        int          cyc;
        k = 0;
        cyc = 0;
        while (k < case_nvtx[c]) begin
            @(negedge clk);
            rnd = $random(seed);
            case (case_mode[c])
                0: out_ready = 1'b1;
                1: out_ready = rnd[0];
                default: out_ready = (cyc % 3 == 0);
            endcase
            cyc++;
            #1;
            if (out_valid && out_ready) begin
                got = '{x: out_x, y: out_y, z: out_z, w: out_w, last: out_last};
                check_vertex(got, exp_tab[case_first[c] + k],
                             $sformatf("case %0d vertex %0d", c, k));
                k++;
            end
        end
        // Keep any extra output visible at the head
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic wait_input_full();
        int cyc;
        cyc = 0;
        while (!(sent >= FIFO_DEPTH && !vtx_ready) && cyc < 200) begin
            @(negedge clk);
            #2;
            cyc++;
        end
        if (sent != FIFO_DEPTH || vtx_ready) begin
            report_failure("input FIFO did not fill to its depth before the commit");
        end
        check_bit(out_valid, 1'b0, "output before any commit");
    endtask

    task automatic finish_batch();
        logic [APB_DW-1:0] d;
        logic              e;
        wait_status(32'h2, "done after the last vertex", d);
        check_word(d, 32'h2, "status after batch");
        apb_write(ADDR_STATUS, 32'h2, e);
        apb_read(ADDR_STATUS, d, e);
        check_word(d, 32'h0, "status after clearing done");
        check_bit(out_valid, 1'b0, "extra output after the batch");
    endtask

    task automatic run_case(input int c);
        sent = 0;
        if (!case_late[c]) begin
            load_matrix(c);
        end
        fork
            send_vertices(c);
            collect_outputs(c);
            begin
                if (case_late[c]) begin
                    wait_input_full();
                    load_matrix(c);
                end
            end
        join
        finish_batch();
    endtask

    initial begin
        int   limit;
        wait (table_ready);
        limit = 2000;
        for (int c = 0; c < N_CASES; c++) begin
            limit += 200 * case_nvtx[c];
        end
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic [APB_DW-1:0] d;
        logic              e;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        vtx_valid = 1'b0;
        vtx_x = '0;
        vtx_y = '0;
        vtx_z = '0;
        vtx_last = 1'b0;
        out_ready = 1'b0;
        err_count = 0;
        sent = 0;
        table_ready = 1'b0;
        seed = 59358;
        build_table();

        repeat (2) @(negedge clk);
        check_bit(vtx_ready, 1'b0, "vertex ready in reset");
        check_bit(out_valid, 1'b0, "output valid in reset");
        check_bit(pslverr, 1'b0, "slave error in reset");
        check_bit(uut.u_shader.o_ready, 1'b0, "shader ready in reset");
        check_bit(uut.u_shader.o_finished, 1'b0, "finished in reset");
        check_bit(uut.u_regs.o_mvp_dv, 1'b0, "commit pulse in reset");
        wait (rstn === 1'b1);
        @(negedge clk);

        // Accesses outside the register map
        apb_read(8'h48, d, e);
        check_bit(e, 1'b1, "slave error on unmapped read");
        apb_write(8'hFC, 32'h1, e);
        check_bit(e, 1'b1, "slave error on unmapped write");

        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end

        repeat (4) @(negedge clk);
        if (err_count == 0 && uut.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim/geom_props.sv */
`timescale 1ns/1ps

module geom_props (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_out_valid,
    input  logic             i_out_ready,
    input  geom_pkg::coord_t i_out_x,
    input  geom_pkg::coord_t i_out_y,
    input  geom_pkg::coord_t i_out_z,
    input  geom_pkg::coord_t i_out_w,
    input  logic             i_out_last,
    input  logic             i_vertex_dv,
    input  logic             i_fifo_ready,
    input  logic             i_pready
);

    int unsigned fail_count = 0;

    // Output head held while the sink stalls
    out_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_out_valid && !i_out_ready |=> i_out_valid
            && $stable({i_out_x, i_out_y, i_out_z, i_out_w, i_out_last}))
    else begin
        fail_count++;
        $error("output stream changed while the sink was stalled");
    end

    // Every shader result finds room in the output FIFO
    out_room: assert property (@(posedge clk) disable iff (!rstn)
        i_vertex_dv |-> i_fifo_ready)
    else begin
        fail_count++;
        $error("shader result arrived at a full output FIFO");
    end

    pready_high: assert property (@(posedge clk) i_pready)
    else begin
        fail_count++;
        $error("APB pready went low");
    end

endmodule

bind geom_top geom_props u_props (
    .clk          (clk),
    .rstn         (rstn),
    .i_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready),
    .i_out_x      (o_out_x),
    .i_out_y      (o_out_y),
    .i_out_z      (o_out_z),
    .i_out_w      (o_out_w),
    .i_out_last   (o_out_last),
    .i_vertex_dv  (sh_vertex_dv),
    .i_fifo_ready (u_out_fifo.o_ready),
    .i_pready     (o_pready)
);

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_rstn
);

    localparam time HALF_PERIOD = 10ns;
    localparam int RESET_CYCLES = 8;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the DUT's sampling edge
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rstn = 1'b1;
    end

endmodule

/* design/geom_top.sv */
`timescale 1ns/1ps

module geom_top (
    input  logic                           clk,
    input  logic                           rstn,

    // APB configuration port
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [geom_pkg::APB_AW-1:0]    i_paddr,
    input  logic [geom_pkg::APB_DW-1:0]    i_pwdata,
    output logic [geom_pkg::APB_DW-1:0]    o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,

    // Vertex input stream
    input  logic                           i_vtx_valid,
    output logic                           o_vtx_ready,
    input  geom_pkg::coord_t               i_vtx_x,
    input  geom_pkg::coord_t               i_vtx_y,
    input  geom_pkg::coord_t               i_vtx_z,
    input  logic                           i_vtx_last,

    // Clip-space output stream
    output logic                           o_out_valid,
    input  logic                           i_out_ready,
    output geom_pkg::coord_t               o_out_x,
    output geom_pkg::coord_t               o_out_y,
    output geom_pkg::coord_t               o_out_z,
    output geom_pkg::coord_t               o_out_w,
    output logic                           o_out_last
);
    import geom_pkg::*;

    coord_t      mvp_mat [16];
    logic        mvp_dv;
    logic        sh_ready;
    logic        sh_finished;
    logic        sh_enable;

    in_vertex_t  in_wr;
    in_vertex_t  in_head;
    logic        in_valid;
    coord_t      sh_vtx [3];

    coord_t      sh_vertex [4];
    logic        sh_vertex_last;
    logic        sh_vertex_dv;
    out_vertex_t out_wr;
    out_vertex_t out_head;
    logic        out_almost_full;

    assign in_wr = '{x: i_vtx_x, y: i_vtx_y, z: i_vtx_z, last: i_vtx_last};
    assign sh_vtx = '{in_head.x, in_head.y, in_head.z};

    // Output FIFO keeps room for everything in flight
    assign sh_enable = ~out_almost_full;

    assign out_wr = '{x: sh_vertex[0], y: sh_vertex[1], z: sh_vertex[2],
                      w: sh_vertex[3], last: sh_vertex_last};

    mvp_regs_apb u_regs (
        .clk        (clk),
        .rstn       (rstn),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_mvp_mat  (mvp_mat),
        .o_mvp_dv   (mvp_dv),
        .i_ready    (sh_ready),
        .i_finished (sh_finished)
    );

    stream_fifo #(.T(in_vertex_t)) u_in_fifo (
        .clk           (clk),
        .rstn          (rstn),
        .i_valid       (i_vtx_valid),
        .o_ready       (o_vtx_ready),
        .i_data        (in_wr),
        .o_valid       (in_valid),
        .i_ready       (sh_ready),
        .o_data        (in_head),
        .o_almost_full ()
    );

    vertex_shader u_shader (
        .clk           (clk),
        .rstn          (rstn),
        .i_enable      (sh_enable),
        .i_mvp_mat     (mvp_mat),
        .i_mvp_dv      (mvp_dv),
        .o_ready       (sh_ready),
        .o_finished    (sh_finished),
        .i_vtx_valid   (in_valid),
        .i_vtx         (sh_vtx),
        .i_vtx_last    (in_head.last),
        .o_vertex      (sh_vertex),
        .o_vertex_last (sh_vertex_last),
        .o_vertex_dv   (sh_vertex_dv)
    );

    stream_fifo #(.T(out_vertex_t)) u_out_fifo (
        .clk           (clk),
        .rstn          (rstn),
        .i_valid       (sh_vertex_dv),
        .o_ready       (),
        .i_data        (out_wr),
        .o_valid       (o_out_valid),
        .i_ready       (i_out_ready),
        .o_data        (out_head),
        .o_almost_full (out_almost_full)
    );

    assign o_out_x = out_head.x;
    assign o_out_y = out_head.y;
    assign o_out_z = out_head.z;
    assign o_out_w = out_head.w;
    assign o_out_last = out_head.last;

endmodule

/* design/vertex_shader.sv */
`timescale 1ns/1ps

module vertex_shader (
    input  logic             clk,
    input  logic             rstn,
    input  logic             i_enable,

    // Committed matrix from the register block
    input  geom_pkg::coord_t i_mvp_mat [16],
    input  logic             i_mvp_dv,

    output logic             o_ready,
    output logic             o_finished,

    // Input vertex, xyz only
    input  logic             i_vtx_valid,
    input  geom_pkg::coord_t i_vtx [3],
    input  logic             i_vtx_last,

    // Clip-space vertex
    output geom_pkg::coord_t o_vertex [4],
    output logic             o_vertex_last,
    output logic             o_vertex_dv
);
    import geom_pkg::*;

    shader_state_t state;
    shader_state_t state_nxt;

    coord_t        mvp_q [16];
    logic          mvp_valid;

    coord_t        vtx_q [4];
    logic          vtx_dv;
    logic          vtx_last;

    // Last vertex of the batch is already in flight
    logic          last_pending;

    logic          accept;
    logic          last_out;

    coord_t        mvm_vec [4];
    logic          mvm_dv;
    logic          mvm_last;

    assign accept = i_vtx_valid & o_ready;
    assign last_out = mvm_dv & mvm_last & i_enable;

    mat_vec_mul u_mat_vec_mul (
        .clk      (clk),
        .rstn     (rstn),
        .i_enable (i_enable),
        .i_mat    (mvp_q),
        .i_vec    (vtx_q),
        .i_dv     (vtx_dv),
        .i_last   (vtx_last),
        .o_vec    (mvm_vec),
        .o_dv     (mvm_dv),
        .o_last   (mvm_last)
    );

    // Matrix is dropped as the last vertex leaves the multiplier
    always_ff @(posedge clk) begin
        if (!rstn || last_out) begin
            for (int k = 0; k < 16; k++) begin
                mvp_q[k] <= '0;
            end
            mvp_valid <= 1'b0;
        end else if (i_mvp_dv) begin
            mvp_q <= i_mvp_mat;
            mvp_valid <= 1'b1;
        end
    end

    // Input register, w extended to one
    always_ff @(posedge clk) begin
        if (accept) begin
            vtx_q[0] <= i_vtx[0];
            vtx_q[1] <= i_vtx[1];
            vtx_q[2] <= i_vtx[2];
            vtx_q[3] <= FIXED_ONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vtx_dv <= 1'b0;
            vtx_last <= 1'b0;
            last_pending <= 1'b0;
        end else begin
            if (i_enable) begin
                vtx_dv <= accept;
                vtx_last <= accept & i_vtx_last;
            end
            if (accept && i_vtx_last) begin
                last_pending <= 1'b1;
            end else if (state == FINISHED) begin
                last_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (mvp_valid) begin
                    state_nxt = COMPUTING;
                end
            end
            COMPUTING: begin
                if (last_out) begin
                    state_nxt = FINISHED;
                end
            end
            FINISHED: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // No new vertices once the batch end is in the pipeline
    assign o_ready = (state == COMPUTING) && i_enable && !last_pending;
    assign o_finished = (state == FINISHED);

    assign o_vertex = mvm_vec;
    assign o_vertex_last = mvm_last;
    assign o_vertex_dv = mvm_dv & i_enable;

endmodule

/* design/mat_vec_mul.sv */
`timescale 1ns/1ps

module mat_vec_mul (
    input  logic             clk,
    input  logic             rstn,

    // Stalls every stage when low
    input  logic             i_enable,

    // Row-major matrix and column vector
    input  geom_pkg::coord_t i_mat [16],
    input  geom_pkg::coord_t i_vec [4],
    input  logic             i_dv,
    input  logic             i_last,

    output geom_pkg::coord_t o_vec [4],
    output logic             o_dv,
    output logic             o_last
);
    import geom_pkg::*;

    logic signed [2*DATAWIDTH-1:0] prod [16];
    coord_t                        scaled [16];
    coord_t                        pair [8];
    coord_t                        row [4];

    logic [MVM_LATENCY-1:0]        dv_pipe;
    logic [MVM_LATENCY-1:0]        last_pipe;

    // Stage 1, full-width products
    always_ff @(posedge clk) begin
        if (i_enable) begin
            for (int k = 0; k < 16; k++) begin
                prod[k] <= i_mat[k] * i_vec[k % 4];
            end
        end
    end

    // Stage 2, rescale by arithmetic shift and drop the top bits
    always_ff @(posedge clk) begin
        if (i_enable) begin
            for (int k = 0; k < 16; k++) begin
                scaled[k] <= coord_t'(prod[k] >>> FRACBITS);
            end
        end
    end

    // Stage 3, columns 0+1 and 2+3 of each row
    always_ff @(posedge clk) begin
        if (i_enable) begin
            for (int p = 0; p < 8; p++) begin
                pair[p] <= scaled[2*p] + scaled[2*p+1];
            end
        end
    end

    // Stage 4, row sums, wrapping to DATAWIDTH
    always_ff @(posedge clk) begin
        if (i_enable) begin
            for (int r = 0; r < 4; r++) begin
                row[r] <= pair[2*r] + pair[2*r+1];
            end
        end
    end

    // Valid and last tags ride along with the data
    always_ff @(posedge clk) begin
        if (!rstn) begin
            dv_pipe <= '0;
            last_pipe <= '0;
        end else if (i_enable) begin
            dv_pipe <= {dv_pipe[MVM_LATENCY-2:0], i_dv};
            last_pipe <= {last_pipe[MVM_LATENCY-2:0], i_last & i_dv};
        end
    end

    assign o_vec = row;
    assign o_dv = dv_pipe[MVM_LATENCY-1];
    assign o_last = last_pipe[MVM_LATENCY-1];

endmodule

/* design/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T = geom_pkg::in_vertex_t
) (
    input  logic clk,
    input  logic rstn,

    // Write side
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,

    // Read side
    output logic o_valid,
    input  logic i_ready,
    output T     o_data,

    output logic o_almost_full
);
    import geom_pkg::*;

    T                   mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic [FIFO_AW:0]   count_nxt;
    logic               push;
    logic               pop;

    assign push = i_valid & o_ready;
    assign pop = o_valid & i_ready;
    assign count_nxt = count + (FIFO_AW + 1)'(push) - (FIFO_AW + 1)'(pop);

    assign o_valid = (count != '0);
    assign o_data = mem[rd_ptr];

    // Fewer than SHADER_LATENCY+1 free entries left
    assign o_almost_full = (count > (FIFO_AW + 1)'(FIFO_DEPTH - SHADER_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            o_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_nxt;
            // Registered so it stays low through reset
            o_ready <= (count_nxt != (FIFO_AW + 1)'(FIFO_DEPTH));
        end
    end

endmodule

/* design/mvp_regs_apb.sv */
`timescale 1ns/1ps

module mvp_regs_apb (
    input  logic                           clk,
    input  logic                           rstn,

    // APB slave
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [geom_pkg::APB_AW-1:0]    i_paddr,
    input  logic [geom_pkg::APB_DW-1:0]    i_pwdata,
    output logic [geom_pkg::APB_DW-1:0]    o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,

    // Matrix to the shader
    output geom_pkg::coord_t               o_mvp_mat [16],
    output logic                           o_mvp_dv,
    input  logic                           i_ready,
    input  logic                           i_finished
);
    import geom_pkg::*;

    coord_t              mat_q [16];
    logic                done_q;
    logic                access;
    logic                wr_en;
    logic [APB_AW-1:0]   mat_off;
    logic [3:0]          mat_idx;
    logic                addr_is_mat;
    logic                addr_ok;

    assign access = i_psel & i_penable;

    // Sixteen words from the base, word aligned
    assign mat_off = i_paddr - ADDR_MAT_BASE;
    assign mat_idx = mat_off[5:2];
    assign addr_is_mat = (mat_off[1:0] == 2'b00) && (mat_off[APB_AW-1:6] == '0);
    assign addr_ok = addr_is_mat || (i_paddr == ADDR_CTRL) || (i_paddr == ADDR_STATUS);

    assign wr_en = access & i_pwrite & addr_ok;

    // Zero wait states
    assign o_pready = 1'b1;
    assign o_pslverr = access & ~addr_ok;

    always_comb begin
        o_prdata = '0;
        if (addr_is_mat) begin
            // Sign-extend the stored entry
            o_prdata = {{(APB_DW - DATAWIDTH){mat_q[mat_idx][DATAWIDTH-1]}}, mat_q[mat_idx]};
        end else if (i_paddr == ADDR_STATUS) begin
            o_prdata[0] = i_ready;
            o_prdata[1] = done_q;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && addr_is_mat) begin
            mat_q[mat_idx] <= i_pwdata[DATAWIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mvp_dv <= 1'b0;
            done_q <= 1'b0;
        end else begin
            // Commit pulse, one cycle
            o_mvp_dv <= wr_en && (i_paddr == ADDR_CTRL) && i_pwdata[0];

            // Set wins over a clear in the same cycle
            if (i_finished) begin
                done_q <= 1'b1;
            end else if (wr_en && (i_paddr == ADDR_STATUS) && i_pwdata[1]) begin
                done_q <= 1'b0;
            end
        end
    end

    assign o_mvp_mat = mat_q;

endmodule

/* design/geom_pkg.sv */
package geom_pkg;

    // Fixed-point format, Q10.13 in 24 bits
    localparam int unsigned DATAWIDTH = 24;
    localparam int unsigned FRACBITS = 13;

    typedef logic signed [DATAWIDTH-1:0] coord_t;

    localparam coord_t FIXED_ONE = coord_t'(1 << FRACBITS);

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        logic   last;
    } in_vertex_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        coord_t w;
        logic   last;
    } out_vertex_t;

    // Pipeline depths and buffering
    localparam int unsigned MVM_LATENCY = 4;
    localparam int unsigned SHADER_LATENCY = 5;
    localparam int unsigned FIFO_DEPTH = 16;
    localparam int unsigned FIFO_AW = $clog2(FIFO_DEPTH);

    // APB register map
    localparam int unsigned APB_AW = 8;
    localparam int unsigned APB_DW = 32;
    localparam logic [APB_AW-1:0] ADDR_MAT_BASE = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_CTRL = 8'h40;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h44;

    typedef enum logic [1:0] {
        IDLE,
        COMPUTING,
        FINISHED
    } shader_state_t;

endpackage
